/* source/sky_pkg.sv */
`default_nettype none

package sky_pkg;

	// grid geometry.
	localparam int COLUMNS = 30;
	localparam int ROWS = 28;
	localparam int BLOCK = 4;
	localparam int SUBPIXELS = 16;

	typedef logic [4:0] column_t;
	typedef logic [4:0] row_t;
	typedef logic [3:0] subpixel_t;

	// any nonzero cell is occupied.
	typedef logic [1:0] cell_t;

	localparam cell_t CELL_EMPTY = 2'b00;
	localparam cell_t CELL_MEATBALL = 2'b10;

	typedef logic [7:0] x_t;
	typedef logic [6:0] y_t;
	typedef logic [2:0] color_t;

	localparam color_t COLOR_SKY = 3'd0;
	localparam color_t COLOR_MEATBALL = 3'd7;

	typedef logic [11:0] lfsr_t;

	localparam lfsr_t LFSR_SEED = 12'hACE;

	// feedback taps at bits 11, 5, 3 and 0.
	localparam lfsr_t LFSR_TAPS = 12'b1000_0010_1001;

endpackage

`default_nettype wire

/* source/spawn_lfsr.sv */
`default_nettype none

module spawn_lfsr (
	input wire logic clock,
	input wire logic reset,
	output sky_pkg::lfsr_t lfsr_state
);

	import sky_pkg::*;

	logic feedback;

	// xor of the tapped bits enters at bit 0.
	assign feedback = ^(lfsr_state & LFSR_TAPS);

	always_ff @(posedge clock) begin
		if (!reset) begin
			lfsr_state <= LFSR_SEED;
		end else begin
			lfsr_state <= {lfsr_state[10:0], feedback};
		end
	end

endmodule

`default_nettype wire

/* source/meatball_grid.sv */
`default_nettype none

module meatball_grid (
	input wire logic clock,
	input wire logic reset,
	input wire logic update_req,
	output logic update_ack,
	input wire logic drawing,
	input wire sky_pkg::lfsr_t lfsr_state,
	input wire sky_pkg::column_t read_column,
	input wire sky_pkg::row_t read_row,
	output sky_pkg::cell_t read_cell
);

	import sky_pkg::*;

	cell_t cells [COLUMNS][ROWS];
	logic accept;
	logic [4:0] spawn_value;

	// an update waits while a frame is being drawn.
	assign accept = update_req && !update_ack && !drawing;
	assign spawn_value = lfsr_state[4:0];

	always_ff @(posedge clock) begin
		if (!reset) begin
			update_ack <= 1'b0;
		end else if (accept) begin
			update_ack <= 1'b1;
		end else if (!update_req) begin
			update_ack <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int c = 0; c < COLUMNS; c++) begin
				for (int r = 0; r < ROWS; r++) begin
					cells[c][r] <= CELL_EMPTY;
				end
			end
		end else if (accept) begin
			for (int c = 0; c < COLUMNS; c++) begin
				// bottom cell drops off.
				for (int r = ROWS - 1; r > 0; r--) begin
					cells[c][r] <= cells[c][r - 1];
				end
				// values 0 and 31 never match a column.
				if (spawn_value == c + 1) begin
					cells[c][0] <= CELL_MEATBALL;
				end else begin
					cells[c][0] <= CELL_EMPTY;
				end
			end
		end
	end

	always_comb begin
		if (read_column < COLUMNS && read_row < ROWS) begin
			read_cell = cells[read_column][read_row];
		end else begin
			read_cell = CELL_EMPTY;
		end
	end

endmodule

`default_nettype wire

/* source/frame_scanner.sv */
`default_nettype none

module frame_scanner (
	input wire logic clock,
	input wire logic reset,
	input wire logic draw_req,
	output logic draw_ack,
	output logic drawing,
	output sky_pkg::column_t read_column,
	output sky_pkg::row_t read_row,
	output logic cell_valid,
	output sky_pkg::x_t pixel_x,
	output sky_pkg::y_t pixel_y,
	input wire logic cell_take,
	input wire logic painter_idle
);

	import sky_pkg::*;

	column_t column;
	row_t row;
	subpixel_t subpixel;
	logic scan_done;
	logic last_subpixel;
	logic last_row;
	logic last_column;

	assign last_subpixel = subpixel == SUBPIXELS - 1;
	assign last_row = row == ROWS - 1;
	assign last_column = column == COLUMNS - 1;

	assign cell_valid = drawing && !scan_done;
	assign read_column = column;
	assign read_row = row;

	// sub-pixels fill a cell top to bottom, then left to right.
	assign pixel_x = x_t'(column * BLOCK + subpixel / BLOCK);
	assign pixel_y = y_t'(row * BLOCK + subpixel % BLOCK);

	always_ff @(posedge clock) begin
		if (!reset) begin
			drawing <= 1'b0;
			draw_ack <= 1'b0;
			scan_done <= 1'b0;
			column <= '0;
			row <= '0;
			subpixel <= '0;
		end else if (!drawing) begin
			if (draw_req && !draw_ack) begin
				drawing <= 1'b1;
				scan_done <= 1'b0;
				column <= '0;
				row <= '0;
				subpixel <= '0;
			end
		end else if (draw_ack) begin
			if (!draw_req) begin
				draw_ack <= 1'b0;
				drawing <= 1'b0;
			end
		end else if (scan_done) begin
			// last pixel handshake must be finished.
			if (painter_idle) begin
				draw_ack <= 1'b1;
			end
		end else if (cell_take) begin
			if (last_subpixel) begin
				subpixel <= '0;
				if (last_row) begin
					row <= '0;
					if (last_column) begin
						column <= '0;
						scan_done <= 1'b1;
					end else begin
						column <= column + 1'b1;
					end
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				subpixel <= subpixel + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/pixel_painter.sv */
`default_nettype none

module pixel_painter (
	input wire logic clock,
	input wire logic reset,
	input wire logic cell_valid,
	input wire sky_pkg::x_t pixel_x,
	input wire sky_pkg::y_t pixel_y,
	input wire sky_pkg::cell_t read_cell,
	output logic cell_take,
	output logic painter_idle,
	output logic pixel_req,
	input wire logic pixel_ack,
	output sky_pkg::x_t x,
	output sky_pkg::y_t y,
	output sky_pkg::color_t color
);

	import sky_pkg::*;

	color_t cell_color;

	// idle only once the host has dropped its ack too.
	assign painter_idle = !pixel_req && !pixel_ack;
	assign cell_take = cell_valid && painter_idle;

	always_comb begin
		if (read_cell != CELL_EMPTY) begin
			cell_color = COLOR_MEATBALL;
		end else begin
			cell_color = COLOR_SKY;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			pixel_req <= 1'b0;
		end else if (cell_take) begin
			pixel_req <= 1'b1;
		end else if (pixel_req && pixel_ack) begin
			pixel_req <= 1'b0;
		end
	end

	// held stable for the whole handshake.
	always_ff @(posedge clock) begin
		if (!reset) begin
			x <= '0;
			y <= '0;
			color <= COLOR_SKY;
		end else if (cell_take) begin
			x <= pixel_x;
			y <= pixel_y;
			color <= cell_color;
		end
	end

endmodule

`default_nettype wire

/* source/sky.sv */
`default_nettype none

module sky (
	input wire logic clock,
	input wire logic reset,
	input wire logic update_req,
	output logic update_ack,
	input wire logic draw_req,
	output logic draw_ack,
	output logic pixel_req,
	input wire logic pixel_ack,
	output sky_pkg::x_t x,
	output sky_pkg::y_t y,
	output sky_pkg::color_t color
);

	import sky_pkg::*;

	lfsr_t lfsr_state;
	column_t read_column;
	row_t read_row;
	cell_t read_cell;
	logic drawing;
	logic cell_valid;
	logic cell_take;
	logic painter_idle;
	x_t pixel_x;
	y_t pixel_y;

	spawn_lfsr i_spawn_lfsr (
		.clock(clock),
		.reset(reset),
		.lfsr_state(lfsr_state)
	);

	meatball_grid i_meatball_grid (
		.clock(clock),
		.reset(reset),
		.update_req(update_req),
		.update_ack(update_ack),
		.drawing(drawing),
		.lfsr_state(lfsr_state),
		.read_column(read_column),
		.read_row(read_row),
		.read_cell(read_cell)
	);

	frame_scanner i_frame_scanner (
		.clock(clock),
		.reset(reset),
		.draw_req(draw_req),
		.draw_ack(draw_ack),
		.drawing(drawing),
		.read_column(read_column),
		.read_row(read_row),
		.cell_valid(cell_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.cell_take(cell_take),
		.painter_idle(painter_idle)
	);

	pixel_painter i_pixel_painter (
		.clock(clock),
		.reset(reset),
		.cell_valid(cell_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.read_cell(read_cell),
		.cell_take(cell_take),
		.painter_idle(painter_idle),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack),
		.x(x),
		.y(y),
		.color(color)
	);

endmodule

`default_nettype wire

/* tests/sky_model.sv */
`default_nettype none

module sky_model (
	input wire logic clock,
	input wire logic reset,
	input wire logic update_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	import sky_pkg::*;

	cell_t grid [COLUMNS][ROWS];
	lfsr_t lfsr;
	lfsr_t lfsr_before;
	logic ack_seen;

	function automatic lfsr_t lfsr_step(input lfsr_t state);
		return {state[10:0], state[11] ^ state[5] ^ state[3] ^ state[0]};
	endfunction

	// pixel index n counts sub-pixels fastest, then rows, then columns.
	function automatic x_t expected_x(input int n);
		int column;
		int subpixel;
		column = n / (ROWS * SUBPIXELS);
		subpixel = n % SUBPIXELS;
		return x_t'(column * BLOCK + subpixel / 4);
	endfunction

	function automatic y_t expected_y(input int n);
		int row;
		int subpixel;
		row = (n / SUBPIXELS) % ROWS;
		subpixel = n % SUBPIXELS;
		return y_t'(row * BLOCK + subpixel % 4);
	endfunction

	function automatic color_t expected_color(input int n);
		int column;
		int row;
		column = n / (ROWS * SUBPIXELS);
		row = (n / SUBPIXELS) % ROWS;
		return (grid[column][row] != CELL_EMPTY) ? COLOR_MEATBALL : COLOR_SKY;
	endfunction

	task automatic apply_update(input logic [4:0] spawn);
		for (int c = 0; c < COLUMNS; c++) begin
			for (int r = ROWS - 1; r > 0; r--) begin
				grid[c][r] = grid[c][r - 1];
			end
			grid[c][0] = (int'(spawn) == c + 1) ? CELL_MEATBALL : CELL_EMPTY;
		end
	endtask

	always @(posedge clock) begin
		lfsr_before <= lfsr;
		if (!reset) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= lfsr_step(lfsr);
		end
	end

	always @(negedge clock) begin
		if (!reset) begin
			for (int c = 0; c < COLUMNS; c++) begin
				for (int r = 0; r < ROWS; r++) begin
					grid[c][r] = CELL_EMPTY;
				end
			end
			ack_seen = 1'b0;
		end else begin
			// the spawn uses the state from before the accepting edge.
			if (update_ack && !ack_seen) begin
				apply_update(lfsr_before[4:0]);
			end
			ack_seen = update_ack;
		end
	end

endmodule

`default_nettype wire

/* tests/sky_tb.sv */
`default_nettype none

module sky_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import sky_pkg::*;

	localparam int CLOCK_PERIOD = 100;
	localparam int PIXELS = COLUMNS * ROWS * SUBPIXELS;
	localparam int FRAMES = 10;
	localparam int UPDATES = 40;
	// longest pixel handshake with a 3-cycle ack delay, with margin.
	localparam int HANDSHAKE_CYCLES = 8;
	localparam int UPDATE_CYCLES = 16;
	localparam longint TIME_LIMIT = (longint'(FRAMES) * PIXELS * HANDSHAKE_CYCLES
		+ UPDATES * UPDATE_CYCLES + 1000) * CLOCK_PERIOD;

	logic clock;
	logic reset;
	logic update_req;
	logic update_ack;
	logic draw_req;
	logic draw_ack;
	logic pixel_req;
	logic pixel_ack;
	x_t x;
	y_t y;
	color_t color;
	integer seed;

	sky i_sky (
		.clock(clock),
		.reset(reset),
		.update_req(update_req),
		.update_ack(update_ack),
		.draw_req(draw_req),
		.draw_ack(draw_ack),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack),
		.x(x),
		.y(y),
		.color(color)
	);

	sky_model i_model (
		.clock(clock),
		.reset(reset),
		.update_ack(update_ack)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	initial begin
		#(TIME_LIMIT);
		$display("watchdog: the run timed out before all tests finished");
		abort_run();
	end

	function automatic int random_below(input int limit);
		return $unsigned($random(seed)) % limit;
	endfunction

	task automatic check_flag(input string name, input logic want, input logic got);
		if (got !== want) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, want, got);
			abort_run();
		end
	endtask

	task automatic check_pixel(input string name, input x_t want_x, input y_t want_y,
		input color_t want_color, input x_t got_x, input y_t got_y, input color_t got_color);
		if (got_x !== want_x || got_y !== want_y || got_color !== want_color) begin
			$display("CHECK FAILED %s: expected x=%0d y=%0d color=%0d, actual x=%0d y=%0d color=%0d",
				name, want_x, want_y, want_color, got_x, got_y, got_color);
			abort_run();
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(negedge clock);
	endtask

	task automatic apply_reset();
		reset = 1'b0;
		update_req = 1'b0;
		draw_req = 1'b0;
		pixel_ack = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
	endtask

	task automatic request_update();
		idle_cycles(random_below(8));
		@(negedge clock);
		update_req = 1'b1;
		while (!update_ack) @(negedge clock);
		update_req = 1'b0;
		while (update_ack) @(negedge clock);
	endtask

	// an update raised while a frame is still going out.
	task automatic late_update();
		logic draw_ack_seen;
		draw_ack_seen = 1'b0;
		while (!draw_req) @(negedge clock);
		idle_cycles(5 + random_below(40));
		update_req = 1'b1;
		while (!update_ack) begin
			@(negedge clock);
			if (draw_ack) begin
				draw_ack_seen = 1'b1;
			end
		end
		check_flag("update_ack held until draw_ack fell", 1'b1, draw_ack_seen && !draw_ack);
		update_req = 1'b0;
		while (update_ack) @(negedge clock);
	endtask

	// acks each pixel after a random delay; returns early after stop_after pixels.
	task automatic draw_frame(input int stop_after, input logic all_sky);
		int n;
		color_t want;
		n = 0;
		idle_cycles(random_below(8));
		@(negedge clock);
		draw_req = 1'b1;
		while (!draw_ack) begin
			@(negedge clock);
			if (pixel_req) begin
				check_flag("pixel inside frame", 1'b1, n < PIXELS);
				want = all_sky ? COLOR_SKY : i_model.expected_color(n);
				check_pixel($sformatf("pixel %0d", n), i_model.expected_x(n),
					i_model.expected_y(n), want, x, y, color);
				idle_cycles(random_below(4));
				pixel_ack = 1'b1;
				while (pixel_req) @(negedge clock);
				check_flag("draw_ack before pixel handshake ends", 1'b0, draw_ack);
				pixel_ack = 1'b0;
				n++;
				if (n == stop_after && n < PIXELS) begin
					return;
				end
			end
		end
		check_flag("draw_ack after the last pixel", 1'b1, n == PIXELS);
		check_flag("pixel_req low at draw_ack", 1'b0, pixel_req);
		draw_req = 1'b0;
		while (draw_ack) @(negedge clock);
	endtask

	initial begin
		int count;
		seed = 32'he4ef_63cd;
		apply_reset();
		check_flag("update_ack after reset", 1'b0, update_ack);
		check_flag("draw_ack after reset", 1'b0, draw_ack);
		check_flag("pixel_req after reset", 1'b0, pixel_req);
		draw_frame(PIXELS, 1'b1);

		for (int i = 0; i < 3; i++) begin
			request_update();
			draw_frame(PIXELS, 1'b0);
		end

		// enough updates to push the first meatballs off the bottom.
		count = 29 + random_below(4);
		repeat (count) request_update();
		draw_frame(PIXELS, 1'b0);
		count = 1 + random_below(4);
		repeat (count) request_update();
		draw_frame(PIXELS, 1'b0);

		fork
			draw_frame(PIXELS, 1'b0);
			late_update();
		join
		draw_frame(PIXELS, 1'b0);

		// reset part way through a frame.
		draw_frame(1 + random_below(2000), 1'b0);
		apply_reset();
		check_flag("update_ack after mid-frame reset", 1'b0, update_ack);
		check_flag("draw_ack after mid-frame reset", 1'b0, draw_ack);
		check_flag("pixel_req after mid-frame reset", 1'b0, pixel_req);
		check_pixel("outputs after mid-frame reset", '0, '0, COLOR_SKY, x, y, color);
		draw_frame(PIXELS, 1'b1);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/sky_pkg.sv
source/spawn_lfsr.sv
source/meatball_grid.sv
source/frame_scanner.sv
source/pixel_painter.sv
source/sky.sv
tests/sky_model.sv
tests/sky_tb.sv
